//--- verilog/pwo_pkg.sv
// Shared types and constants for the pointwise polynomial unit
package pwo_pkg;

    // ====================
    // Field widths
    // ====================
    localparam int COEFF_W         = 23;
    localparam int SLOT_W          = 24;
    localparam int COEFFS_PER_WORD = 4;
    localparam int PROD_W          = 2 * COEFF_W;
    localparam int MEM_ADDR_W      = 15;
    localparam int MEM_WORD_W      = SLOT_W * COEFFS_PER_WORD;

    // ML-DSA prime
    localparam logic [COEFF_W-1:0] PWO_Q = 23'd8380417;

    // ====================
    // Vector types
    // ====================
    typedef logic [COEFF_W-1:0]                 coeff_t;
    typedef logic [SLOT_W-1:0]                  slot_t;
    typedef logic [PROD_W-1:0]                  prod_t;
    typedef logic [MEM_WORD_W-1:0]              mem_word_t;
    typedef logic [MEM_ADDR_W-1:0]              mem_addr_t;
    // Four coefficients without slot padding
    typedef logic [COEFFS_PER_WORD*COEFF_W-1:0] coeff_vec_t;

    // ====================
    // Encodings
    // ====================
    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } rw_e;

    typedef enum logic [1:0] {
        PWO_MUL = 2'd0,
        PWO_ADD = 2'd1,
        PWO_SUB = 2'd2
    } pwo_op_e;

    // ====================
    // Bundles
    // ====================
    typedef struct packed {
        rw_e       rw;
        mem_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        mem_addr_t a;
        mem_addr_t b;
        mem_addr_t c;
    } pwo_base_t;

    // acc_en only ever set for a multiply
    typedef struct packed {
        pwo_op_e op;
        logic    acc_en;
    } pwo_cfg_t;

    // Tag that follows one memory word from read to write
    typedef struct packed {
        logic      valid;
        logic      last;
        mem_addr_t dest_addr;
    } pwo_issue_t;

endpackage

//--- verilog/pwo_sequencer.sv
// Pointwise run controller that walks the polynomial and issues operand reads
module pwo_sequencer #(
    parameter int POLY_WORDS = 64
) (
    input  logic                clk,
    input  logic                reset_n,

    input  logic                start_i,
    input  pwo_pkg::pwo_op_e    op_i,
    input  logic                accumulate_i,
    input  pwo_pkg::pwo_base_t  base_i,

    input  logic                done_i,

    output pwo_pkg::pwo_cfg_t   cfg_o,
    output pwo_pkg::pwo_issue_t issue_o,

    output pwo_pkg::mem_req_t   a_rd_req_o,
    output pwo_pkg::mem_req_t   b_rd_req_o,
    output pwo_pkg::mem_req_t   c_rd_req_o,

    output logic                busy_o
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2
    } seq_state_e;

    seq_state_e         state;
    pwo_pkg::mem_addr_t word_cnt;
    pwo_pkg::pwo_cfg_t  cfg_q;
    pwo_pkg::pwo_base_t base_q;
    logic               issuing;
    logic               last_word;

    assign issuing   = (state == ISSUE);
    assign last_word = (word_cnt == pwo_pkg::mem_addr_t'(POLY_WORDS - 1));

    // ====================
    // Run state machine
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= IDLE;
            word_cnt <= '0;
            cfg_q    <= '0;
            base_q   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // Strobes while busy never reach this branch
                    if (start_i) begin
                        state        <= ISSUE;
                        word_cnt     <= '0;
                        cfg_q.op     <= op_i;
                        cfg_q.acc_en <= accumulate_i && (op_i == pwo_pkg::PWO_MUL);
                        base_q       <= base_i;
                    end
                end
                ISSUE: begin
                    if (last_word) begin
                        state    <= DRAIN;
                        word_cnt <= '0;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                DRAIN: begin
                    // Wait for the final write to retire
                    if (done_i) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ====================
    // Read requests and issue tag
    // ====================
    always_comb begin
        a_rd_req_o.rw   = issuing ? pwo_pkg::RW_READ : pwo_pkg::RW_IDLE;
        a_rd_req_o.addr = issuing ? base_q.a + word_cnt : '0;
        b_rd_req_o.rw   = issuing ? pwo_pkg::RW_READ : pwo_pkg::RW_IDLE;
        b_rd_req_o.addr = issuing ? base_q.b + word_cnt : '0;

        // Old destination word only needed when accumulating
        c_rd_req_o.rw   = (issuing && cfg_q.acc_en) ? pwo_pkg::RW_READ : pwo_pkg::RW_IDLE;
        c_rd_req_o.addr = (issuing && cfg_q.acc_en) ? base_q.c + word_cnt : '0;

        issue_o.valid     = issuing;
        issue_o.last      = issuing && last_word;
        issue_o.dest_addr = issuing ? base_q.c + word_cnt : '0;
    end

    assign cfg_o  = cfg_q;
    assign busy_o = (state != IDLE);

endmodule

//--- verilog/pwo_lane.sv
// One coefficient lane of modular multiply, add, subtract and accumulate
module pwo_lane (
    input  logic              clk,
    input  logic              reset_n,
    input  pwo_pkg::coeff_t   a_i,
    input  pwo_pkg::coeff_t   b_i,
    input  pwo_pkg::coeff_t   c_i,
    input  pwo_pkg::pwo_cfg_t cfg_i,
    output pwo_pkg::coeff_t   r_o
);

    pwo_pkg::prod_t             raw_d;
    pwo_pkg::prod_t             raw_q;
    pwo_pkg::coeff_t            c_q;
    pwo_pkg::coeff_t            red;
    logic [pwo_pkg::COEFF_W:0]  acc_sum;

    // ====================
    // Stage 1 raw value
    // ====================
    always_comb begin
        case (cfg_i.op)
            pwo_pkg::PWO_MUL: raw_d = pwo_pkg::prod_t'(a_i) * pwo_pkg::prod_t'(b_i);
            pwo_pkg::PWO_ADD: raw_d = pwo_pkg::prod_t'(a_i) + pwo_pkg::prod_t'(b_i);
            // Offset by Q so the difference never goes negative
            pwo_pkg::PWO_SUB: raw_d = pwo_pkg::prod_t'(a_i) + pwo_pkg::prod_t'(pwo_pkg::PWO_Q)
                                      - pwo_pkg::prod_t'(b_i);
            default:          raw_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            raw_q <= '0;
            c_q   <= '0;
        end else begin
            raw_q <= raw_d;
            c_q   <= cfg_i.acc_en ? c_i : '0;
        end
    end

    // ====================
    // Stage 2 reduction
    // ====================
    // Full reduction of the raw value, then add c
    assign red     = pwo_pkg::coeff_t'(raw_q % pwo_pkg::prod_t'(pwo_pkg::PWO_Q));
    assign acc_sum = {1'b0, red} + {1'b0, c_q};

    // Both terms below Q so one conditional subtract is enough
    assign r_o = (acc_sum >= {1'b0, pwo_pkg::PWO_Q})
               ? pwo_pkg::coeff_t'(acc_sum - {1'b0, pwo_pkg::PWO_Q})
               : pwo_pkg::coeff_t'(acc_sum);

endmodule

//--- verilog/pwo_datapath.sv
// Operand capture and four-lane pointwise arithmetic with matching tag pipeline
module pwo_datapath (
    input  logic                clk,
    input  logic                reset_n,
    input  pwo_pkg::pwo_cfg_t   cfg_i,
    input  pwo_pkg::pwo_issue_t issue_i,
    input  pwo_pkg::mem_word_t  a_word_i,
    input  pwo_pkg::mem_word_t  b_word_i,
    input  pwo_pkg::mem_word_t  c_word_i,
    output pwo_pkg::coeff_vec_t result_o,
    output pwo_pkg::pwo_issue_t issue_o
);

    localparam int TAG_STAGES = 3;

    pwo_pkg::pwo_issue_t issue_sr [TAG_STAGES];
    pwo_pkg::mem_word_t  a_q;
    pwo_pkg::mem_word_t  b_q;
    pwo_pkg::mem_word_t  c_q;

    // ====================
    // Tag pipeline
    // ====================
    // Stage 0 lines up with read data, stage 2 with lane results
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < TAG_STAGES; i++) begin
                issue_sr[i] <= '0;
            end
        end else begin
            issue_sr[0] <= issue_i;
            for (int i = 1; i < TAG_STAGES; i++) begin
                issue_sr[i] <= issue_sr[i-1];
            end
        end
    end

    assign issue_o = issue_sr[TAG_STAGES-1];

    // ====================
    // Operand capture
    // ====================
    always_ff @(posedge clk) begin
        if (issue_sr[0].valid) begin
            a_q <= a_word_i;
            b_q <= b_word_i;
            c_q <= c_word_i;
        end
    end

    // ====================
    // Lanes
    // ====================
    // Top bit of each slot is padding and is dropped here
    for (genvar g = 0; g < pwo_pkg::COEFFS_PER_WORD; g++) begin : g_lane
        pwo_lane u_lane (
            .clk     (clk),
            .reset_n (reset_n),
            .a_i     (a_q[g*pwo_pkg::SLOT_W +: pwo_pkg::COEFF_W]),
            .b_i     (b_q[g*pwo_pkg::SLOT_W +: pwo_pkg::COEFF_W]),
            .c_i     (c_q[g*pwo_pkg::SLOT_W +: pwo_pkg::COEFF_W]),
            .cfg_i   (cfg_i),
            .r_o     (result_o[g*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W])
        );
    end

endmodule

//--- verilog/pwo_writeback.sv
// Result packing, destination write and run completion for the pointwise unit
module pwo_writeback (
    input  logic                clk,
    input  logic                reset_n,
    input  pwo_pkg::coeff_vec_t result_i,
    input  pwo_pkg::pwo_issue_t issue_i,
    output pwo_pkg::mem_req_t   wr_req_o,
    output pwo_pkg::mem_word_t  wr_data_o,
    output logic                done_o
);

    pwo_pkg::mem_word_t packed_word;
    pwo_pkg::mem_req_t  wr_req_q;
    pwo_pkg::mem_word_t wr_data_q;
    logic               last_wr_q;
    logic               last_wr_d;
    logic               done_q;

    // Zero pad each coefficient into its 24-bit slot
    always_comb begin
        for (int i = 0; i < pwo_pkg::COEFFS_PER_WORD; i++) begin
            packed_word[i*pwo_pkg::SLOT_W +: pwo_pkg::SLOT_W] =
                pwo_pkg::slot_t'(result_i[i*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W]);
        end
    end

    // ====================
    // Write request and completion
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_req_q  <= '{rw: pwo_pkg::RW_IDLE, addr: '0};
            last_wr_q <= 1'b0;
            last_wr_d <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            wr_req_q.rw   <= issue_i.valid ? pwo_pkg::RW_WRITE : pwo_pkg::RW_IDLE;
            wr_req_q.addr <= issue_i.valid ? issue_i.dest_addr : '0;
            last_wr_q     <= issue_i.valid && issue_i.last;
            // Done trails the final write by one settle cycle
            last_wr_d     <= last_wr_q;
            done_q        <= last_wr_d;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i.valid) begin
            wr_data_q <= packed_word;
        end
    end

    assign wr_req_o  = wr_req_q;
    assign wr_data_o = wr_data_q;
    assign done_o    = done_q;

endmodule

//--- verilog/pwo_top.sv
// Pointwise polynomial unit for multiply, add and subtract modulo the ML-DSA prime
module pwo_top #(
    parameter int POLY_WORDS = 64
) (
    input  logic               clk,
    input  logic               reset_n,

    // Run control
    input  logic               pwo_start_i,
    input  pwo_pkg::pwo_op_e   op_i,
    input  logic               accumulate_i,
    input  pwo_pkg::pwo_base_t base_i,

    // Operand and destination read ports
    output pwo_pkg::mem_req_t  a_rd_req_o,
    output pwo_pkg::mem_req_t  b_rd_req_o,
    output pwo_pkg::mem_req_t  c_rd_req_o,
    input  pwo_pkg::mem_word_t a_rd_data_i,
    input  pwo_pkg::mem_word_t b_rd_data_i,
    input  pwo_pkg::mem_word_t c_rd_data_i,

    // Destination write port
    output pwo_pkg::mem_req_t  wr_req_o,
    output pwo_pkg::mem_word_t wr_data_o,

    output logic               busy_o,
    output logic               done_o
);

    pwo_pkg::pwo_cfg_t   cfg;
    pwo_pkg::pwo_issue_t seq_issue;
    pwo_pkg::pwo_issue_t dp_issue;
    pwo_pkg::coeff_vec_t result;
    logic                done;

    // ====================
    // Input side
    // ====================
    pwo_sequencer #(
        .POLY_WORDS (POLY_WORDS)
    ) u_sequencer (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (pwo_start_i),
        .op_i         (op_i),
        .accumulate_i (accumulate_i),
        .base_i       (base_i),
        .done_i       (done),
        .cfg_o        (cfg),
        .issue_o      (seq_issue),
        .a_rd_req_o   (a_rd_req_o),
        .b_rd_req_o   (b_rd_req_o),
        .c_rd_req_o   (c_rd_req_o),
        .busy_o       (busy_o)
    );

    // ====================
    // Arithmetic
    // ====================
    pwo_datapath u_datapath (
        .clk      (clk),
        .reset_n  (reset_n),
        .cfg_i    (cfg),
        .issue_i  (seq_issue),
        .a_word_i (a_rd_data_i),
        .b_word_i (b_rd_data_i),
        .c_word_i (c_rd_data_i),
        .result_o (result),
        .issue_o  (dp_issue)
    );

    // ====================
    // Output side
    // ====================
    pwo_writeback u_writeback (
        .clk       (clk),
        .reset_n   (reset_n),
        .result_i  (result),
        .issue_i   (dp_issue),
        .wr_req_o  (wr_req_o),
        .wr_data_o (wr_data_o),
        .done_o    (done)
    );

    assign done_o = done;

endmodule

//--- include/pwo_tb_tasks.svh
// Directed tests and check helpers for the pointwise unit testbench
`ifndef PWO_TB_TASKS_SVH
`define PWO_TB_TASKS_SVH

// ====================
// Reporting
// ====================
task automatic report_mismatch(input string sig, input logic [95:0] exp, input logic [95:0] act);
    $display("ERROR at %0t: %s expected %h, got %h", $time, sig, exp, act);
    err_count++;
endtask

task automatic report_failure(input string what);
    $display("At %0t: %s", $time, what);
    err_count++;
endtask

task automatic close_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
        $display("%s: ok", name);
        tests_ok++;
    end else begin
        $display("%s: %0d errors", name, err_count - errs_before);
        tests_bad++;
    end
endtask

// ====================
// Monitor hooks
// ====================
task automatic check_write(input pwo_pkg::mem_addr_t addr, input pwo_pkg::mem_word_t data);
    int offset;
    offset = int'(addr) - int'(win_lo);
    wr_count++;
    if (offset < 0 || offset >= POLY_WORDS) begin
        report_failure($sformatf("write to address 0x%h outside the destination", addr));
    end
    for (int s = 0; s < 4; s++) begin
        if (data[s*24 + 23] !== 1'b0) begin
            report_failure($sformatf("pad bit of slot %0d set in write to 0x%h", s, addr));
        end
    end
endtask

task automatic note_c_read(input pwo_pkg::mem_addr_t addr);
    int offset;
    offset = int'(addr) - int'(win_lo);
    c_rd_count++;
    if (offset < 0 || offset >= POLY_WORDS) begin
        report_failure($sformatf("destination read at 0x%h outside the destination", addr));
    end else begin
        c_rd_seen[offset] = 1'b1;
    end
endtask

// ====================
// Run control
// ====================
function automatic pwo_pkg::pwo_base_t make_base(input pwo_pkg::mem_addr_t dest);
    pwo_pkg::pwo_base_t bs;
    bs.a = A_BASE;
    bs.b = B_BASE;
    bs.c = dest;
    return bs;
endfunction

task automatic clear_run_stats(input pwo_pkg::mem_addr_t dest);
    win_lo     = dest;
    wr_count   = 0;
    done_count = 0;
    c_rd_count = 0;
    c_rd_seen  = '0;
endtask

// One-cycle strobe, returns early in the first cycle after it
task automatic start_run(input pwo_pkg::pwo_op_e run_op, input logic acc,
                         input pwo_pkg::pwo_base_t run_base);
    clear_run_stats(run_base.c);
    @(posedge clk);
    #1;
    pwo_start  = 1'b1;
    op         = run_op;
    accumulate = acc;
    base       = run_base;
    @(posedge clk);
    #1;
    pwo_start = 1'b0;
endtask

task automatic finish_run();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < RUN_CYCLES) begin
        @(negedge clk);
        n++;
        seen = done;
    end
    if (!seen) begin
        report_failure("done_o did not pulse within the length of a run");
    end
    repeat (2) @(negedge clk);
    if (busy !== 1'b0) begin
        report_mismatch("busy_o", 96'(0), 96'(busy));
    end
    if (done_count != 1) begin
        report_failure($sformatf("saw %0d done pulses in one run", done_count));
    end
    if (wr_count != POLY_WORDS) begin
        report_failure($sformatf("saw %0d writes instead of %0d", wr_count, POLY_WORDS));
    end
endtask

task automatic check_results(input pwo_pkg::pwo_op_e run_op, input logic acc,
                             input pwo_pkg::pwo_base_t run_base);
    pwo_pkg::mem_word_t a_w;
    pwo_pkg::mem_word_t b_w;
    pwo_pkg::mem_word_t c_w;
    pwo_pkg::mem_word_t exp_w;
    int                 addr;
    for (int k = 0; k < POLY_WORDS; k++) begin
        a_w   = mem_a[int'(run_base.a) + k];
        b_w   = mem_b[int'(run_base.b) + k];
        // Old destination is the plain product of an earlier multiply run
        c_w   = ref_word(pwo_pkg::PWO_MUL, 1'b0, a_w, b_w, '0);
        exp_w = ref_word(run_op, acc, a_w, b_w, c_w);
        addr  = int'(run_base.c) + k;
        if (mem_c[addr] !== exp_w) begin
            report_mismatch($sformatf("mem_c[0x%h]", addr), exp_w, mem_c[addr]);
        end
    end
endtask

// ====================
// Tests
// ====================
task automatic test_reset_state();
    int errs;
    errs = err_count;
    @(negedge clk);
    if (a_rd_req.rw !== pwo_pkg::RW_IDLE) begin
        report_mismatch("a_rd_req_o.rw", 96'(pwo_pkg::RW_IDLE), 96'(a_rd_req.rw));
    end
    if (b_rd_req.rw !== pwo_pkg::RW_IDLE) begin
        report_mismatch("b_rd_req_o.rw", 96'(pwo_pkg::RW_IDLE), 96'(b_rd_req.rw));
    end
    if (c_rd_req.rw !== pwo_pkg::RW_IDLE) begin
        report_mismatch("c_rd_req_o.rw", 96'(pwo_pkg::RW_IDLE), 96'(c_rd_req.rw));
    end
    if (wr_req.rw !== pwo_pkg::RW_IDLE) begin
        report_mismatch("wr_req_o.rw", 96'(pwo_pkg::RW_IDLE), 96'(wr_req.rw));
    end
    if (busy !== 1'b0 || done !== 1'b0) begin
        report_mismatch("busy_o/done_o", 96'(0), 96'({busy, done}));
    end
    close_test("reset_state", errs);
endtask

task automatic test_pwm();
    int errs;
    errs = err_count;
    start_run(pwo_pkg::PWO_MUL, 1'b0, make_base(15'h1000));
    finish_run();
    check_results(pwo_pkg::PWO_MUL, 1'b0, make_base(15'h1000));
    if (c_rd_count != 0) begin
        report_failure("destination was read during a multiply without accumulate");
    end
    close_test("pwm", errs);
endtask

task automatic test_pwa_pws();
    int errs;
    errs = err_count;
    start_run(pwo_pkg::PWO_ADD, 1'b0, make_base(15'h2000));
    finish_run();
    check_results(pwo_pkg::PWO_ADD, 1'b0, make_base(15'h2000));
    start_run(pwo_pkg::PWO_SUB, 1'b0, make_base(15'h3000));
    finish_run();
    check_results(pwo_pkg::PWO_SUB, 1'b0, make_base(15'h3000));
    close_test("pwa_pws", errs);
endtask

// Accumulates onto the products left by test_pwm
task automatic test_pwm_acc();
    int errs;
    errs = err_count;
    start_run(pwo_pkg::PWO_MUL, 1'b1, make_base(15'h1000));
    finish_run();
    check_results(pwo_pkg::PWO_MUL, 1'b1, make_base(15'h1000));
    if (c_rd_count != POLY_WORDS || c_rd_seen !== '1) begin
        report_failure($sformatf("%0d destination reads, not one per word", c_rd_count));
    end
    close_test("pwm_acc", errs);
endtask

task automatic test_timing();
    int errs;
    errs = err_count;
    start_run(pwo_pkg::PWO_SUB, 1'b0, make_base(15'h4000));
    for (int n = 1; n <= POLY_WORDS + 7; n++) begin
        @(negedge clk);
        if (busy !== (n <= POLY_WORDS + 6)) begin
            report_mismatch($sformatf("busy_o in cycle %0d", n),
                            96'(n <= POLY_WORDS + 6), 96'(busy));
        end
        if (done !== (n == POLY_WORDS + 6)) begin
            report_mismatch($sformatf("done_o in cycle %0d", n),
                            96'(n == POLY_WORDS + 6), 96'(done));
        end
        @(posedge clk);
        #1;
        // Second strobe mid-run with a different op and destination
        pwo_start = (n == 20);
        if (n == 20) begin
            op   = pwo_pkg::PWO_ADD;
            base = make_base(15'h5000);
        end
    end
    if (done_count != 1) begin
        report_failure($sformatf("saw %0d done pulses after a strobe while busy", done_count));
    end
    if (wr_count != POLY_WORDS) begin
        report_failure($sformatf("saw %0d writes instead of %0d", wr_count, POLY_WORDS));
    end
    check_results(pwo_pkg::PWO_SUB, 1'b0, make_base(15'h4000));
    close_test("timing", errs);
endtask

task automatic test_pwa_acc();
    int errs;
    errs = err_count;
    start_run(pwo_pkg::PWO_ADD, 1'b1, make_base(15'h6000));
    finish_run();
    check_results(pwo_pkg::PWO_ADD, 1'b1, make_base(15'h6000));
    if (c_rd_count != 0) begin
        report_failure($sformatf("%0d destination reads on an add run", c_rd_count));
    end
    close_test("pwa_acc", errs);
endtask

`endif

//--- dv/pwo_tb.sv
// Testbench for the pointwise polynomial unit with memory models and a reference model
module pwo_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int     POLY_WORDS   = 64;
    localparam int     RESET_CYCLES = 5;
    localparam int     NUM_RUNS     = 6;
    // Start, issue, pipeline drain and settle cycles of one run
    localparam int     RUN_CYCLES     = POLY_WORDS + 11;
    localparam int     TIMEOUT_CYCLES = 2 * NUM_RUNS * RUN_CYCLES + 100;
    localparam int     MEM_DEPTH      = 1 << pwo_pkg::MEM_ADDR_W;
    localparam longint Q              = 8380417;

    localparam pwo_pkg::mem_addr_t A_BASE = 15'h0100;
    localparam pwo_pkg::mem_addr_t B_BASE = 15'h0200;

    logic                clk;
    logic                reset_n;
    logic                pwo_start;
    pwo_pkg::pwo_op_e    op;
    logic                accumulate;
    pwo_pkg::pwo_base_t  base;
    pwo_pkg::mem_req_t   a_rd_req;
    pwo_pkg::mem_req_t   b_rd_req;
    pwo_pkg::mem_req_t   c_rd_req;
    pwo_pkg::mem_word_t  a_rd_data;
    pwo_pkg::mem_word_t  b_rd_data;
    pwo_pkg::mem_word_t  c_rd_data;
    pwo_pkg::mem_req_t   wr_req;
    pwo_pkg::mem_word_t  wr_data;
    logic                busy;
    logic                done;

    // Operand memories and the destination memory
    pwo_pkg::mem_word_t  mem_a [MEM_DEPTH];
    pwo_pkg::mem_word_t  mem_b [MEM_DEPTH];
    pwo_pkg::mem_word_t  mem_c [MEM_DEPTH];

    // Per-run bookkeeping filled by the memory monitor
    pwo_pkg::mem_addr_t    win_lo;
    int                    wr_count;
    int                    done_count;
    int                    c_rd_count;
    logic [POLY_WORDS-1:0] c_rd_seen;

    int                  err_count;
    int                  tests_ok;
    int                  tests_bad;
    int                  cycle_count;
    logic [15:0]         lfsr;

    pwo_top DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .pwo_start_i  (pwo_start),
        .op_i         (op),
        .accumulate_i (accumulate),
        .base_i       (base),
        .a_rd_req_o   (a_rd_req),
        .b_rd_req_o   (b_rd_req),
        .c_rd_req_o   (c_rd_req),
        .a_rd_data_i  (a_rd_data),
        .b_rd_data_i  (b_rd_data),
        .c_rd_data_i  (c_rd_data),
        .wr_req_o     (wr_req),
        .wr_data_o    (wr_data),
        .busy_o       (busy),
        .done_o       (done)
    );

    always #2 clk = ~clk;

    // ====================
    // Stimulus sources
    // ====================
    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic longint rand_coeff();
        return longint'(take_bits(23)) % Q;
    endfunction

    function automatic logic [23:0] slot_of(input longint v);
        return {1'b0, 23'(v)};
    endfunction

    // Slot pattern carries the full address so stray data is traceable
    function automatic pwo_pkg::mem_word_t background_word(input int addr);
        pwo_pkg::mem_word_t w;
        for (int s = 0; s < 4; s++) begin
            w[s*24 +: 24] = {1'b0, 8'(8'h5A + s), 15'(addr)};
        end
        return w;
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_a[i] = background_word(i);
            mem_b[i] = background_word(i);
            mem_c[i] = background_word(i);
        end
    endtask

    task automatic fill_operands();
        pwo_pkg::mem_word_t wa;
        pwo_pkg::mem_word_t wb;
        for (int k = 0; k < POLY_WORDS; k++) begin
            for (int s = 0; s < 4; s++) begin
                wa[s*24 +: 24] = slot_of(rand_coeff());
                wb[s*24 +: 24] = slot_of(rand_coeff());
            end
            mem_a[int'(A_BASE) + k] = wa;
            mem_b[int'(B_BASE) + k] = wb;
        end
        // Wraparound corners in word 0, slot 0 is the rightmost
        mem_a[int'(A_BASE)] = {slot_of(Q - 1), slot_of(1), slot_of(Q - 1), slot_of(0)};
        mem_b[int'(B_BASE)] = {slot_of(0), slot_of(Q - 1), slot_of(Q - 1), slot_of(1)};
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic pwo_pkg::mem_word_t ref_word(input pwo_pkg::pwo_op_e rop,
                                                    input logic acc,
                                                    input pwo_pkg::mem_word_t a_w,
                                                    input pwo_pkg::mem_word_t b_w,
                                                    input pwo_pkg::mem_word_t c_w);
        pwo_pkg::mem_word_t w;
        longint a;
        longint b;
        longint c;
        longint r;
        for (int s = 0; s < 4; s++) begin
            a = longint'(a_w[s*24 +: 23]);
            b = longint'(b_w[s*24 +: 23]);
            c = longint'(c_w[s*24 +: 23]);
            case (rop)
                pwo_pkg::PWO_MUL: r = (a * b) % Q;
                pwo_pkg::PWO_ADD: r = (a + b) % Q;
                pwo_pkg::PWO_SUB: r = (a - b + Q) % Q;
                default:          r = 0;
            endcase
            // Accumulate applies to multiply only
            if (acc && rop == pwo_pkg::PWO_MUL) begin
                r = (r + c) % Q;
            end
            w[s*24 +: 24] = slot_of(r);
        end
        return w;
    endfunction

    `include "pwo_tb_tasks.svh"

    // ====================
    // Memory ports and monitor
    // ====================
    always @(posedge clk) begin
        if (a_rd_req.rw == pwo_pkg::RW_READ) begin
            a_rd_data <= mem_a[a_rd_req.addr];
        end
        if (b_rd_req.rw == pwo_pkg::RW_READ) begin
            b_rd_data <= mem_b[b_rd_req.addr];
        end
        // Read before write, the two never share an address
        if (c_rd_req.rw == pwo_pkg::RW_READ) begin
            c_rd_data <= mem_c[c_rd_req.addr];
            note_c_read(c_rd_req.addr);
        end
        if (wr_req.rw == pwo_pkg::RW_WRITE) begin
            mem_c[wr_req.addr] = wr_data;
            check_write(wr_req.addr, wr_data);
        end
        if (done) begin
            done_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped at %0t after %0d cycles, a test never finished",
                     $time, cycle_count);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        pwo_start   = 1'b0;
        op          = pwo_pkg::PWO_MUL;
        accumulate  = 1'b0;
        base        = '0;
        a_rd_data  <= '0;
        b_rd_data  <= '0;
        c_rd_data  <= '0;
        err_count   = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        cycle_count = 0;
        lfsr        = 16'd85;
        clear_run_stats('0);
        fill_memories();
        fill_operands();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;

        test_reset_state();
        test_pwm();
        test_pwa_pws();
        test_pwm_acc();
        test_timing();
        test_pwa_acc();

        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
verilog/pwo_pkg.sv
verilog/pwo_sequencer.sv
verilog/pwo_lane.sv
verilog/pwo_datapath.sv
verilog/pwo_writeback.sv
verilog/pwo_top.sv
dv/pwo_tb.sv

//--- run.sh
#!/bin/sh
# Build the pointwise unit testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal -f src.f \
    --top-module pwo_tb -o pwo_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/pwo_sim > sim.log 2>&1
grep -qx "test passed" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED, see sim.log"; exit 1; }
